// File: hw/chess_pkg.sv
package chess_pkg;

   typedef logic [3:0] piece_t;   // bit 3 set for black
   typedef logic [5:0] square_t;  // row in [5:3], column in [2:0]
   typedef piece_t [63:0] board_t;

   localparam logic [2:0] PIECE_EMPTY  = 3'd0;
   localparam logic [2:0] PIECE_PAWN   = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK   = 3'd4;
   localparam logic [2:0] PIECE_QUEEN  = 3'd5;
   localparam logic [2:0] PIECE_KING   = 3'd6;

   localparam int BLACK_BIT = 3;

   typedef struct packed {
      square_t from_sq;
      square_t to_sq;
      piece_t  piece;
      piece_t  captured;
   } move_t;

   typedef struct packed {
      square_t sq;
      piece_t  piece;
      logic    white_to_move;
   } job_t;

   typedef struct packed {
      logic signed [2:0] dr;
      logic signed [2:0] dc;
   } offset_t;

   function automatic offset_t make_offset(input int dr, input int dc);
      offset_t o;
      o.dr = 3'(dr);
      o.dc = 3'(dc);
      return o;
   endfunction

   // returns 1 when the target stays on the board
   function automatic logic step_sq(input square_t from, input offset_t off,
                                    output square_t to);
      logic signed [4:0] r;
      logic signed [4:0] c;
      r = $signed({2'b00, from[5:3]}) + $signed(off.dr);
      c = $signed({2'b00, from[2:0]}) + $signed(off.dc);
      to = {r[2:0], c[2:0]};
      return r >= 0 && r <= 7 && c >= 0 && c <= 7;
   endfunction

   function automatic logic is_own(input piece_t p, input logic white_to_move);
      return p[2:0] != PIECE_EMPTY && p[BLACK_BIT] == !white_to_move;
   endfunction

   function automatic logic is_opponent(input piece_t p, input logic white_to_move);
      return p[2:0] != PIECE_EMPTY && p[BLACK_BIT] == white_to_move;
   endfunction

   // queen takes the rook rays first, then the bishop rays
   function automatic offset_t ray_dir(input logic [2:0] kind, input logic [2:0] idx,
                                       output logic [3:0] count);
      int s;
      count = (kind == PIECE_QUEEN) ? 4'd8 : 4'd4;
      s = idx[0] ? -1 : 1;
      if (kind == PIECE_BISHOP || (kind == PIECE_QUEEN && idx[2]))
         return make_offset(idx[1] ? -1 : 1, s);
      return idx[1] ? make_offset(s, 0) : make_offset(0, s);
   endfunction

   function automatic offset_t leap_offset(input logic [2:0] kind, input logic [2:0] idx);
      int n;
      if (kind == PIECE_KING)
      begin
         n = (idx < 3'd4) ? int'(idx) : int'(idx) + 1;  // skip center of 3x3
         return make_offset(n / 3 - 1, n % 3 - 1);
      end
      case (idx)
         3'd0: return make_offset(-2, -1);
         3'd1: return make_offset(-1, -2);
         3'd2: return make_offset(1, -2);
         3'd3: return make_offset(2, -1);
         3'd4: return make_offset(2, 1);
         3'd5: return make_offset(1, 2);
         3'd6: return make_offset(-1, 2);
         default: return make_offset(-2, 1);
      endcase
   endfunction

endpackage

// File: hw/square_scanner.sv
`timescale 1ns/1ps

module square_scanner
(
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  chess_pkg::board_t board,
   input  logic              white_to_move,
   output chess_pkg::job_t   slide_job,
   output chess_pkg::job_t   leap_job,
   output logic              slide_req,
   output logic              leap_req,
   input  logic              slide_ack,
   input  logic              leap_ack,
   input  logic              slide_busy,
   input  logic              leap_busy,
   output logic              scan_done
);

   typedef enum logic [1:0] {IDLE, SCAN, REQ, DONE} state_t;

   state_t             state;
   chess_pkg::square_t sq;
   chess_pkg::piece_t  cur;
   chess_pkg::job_t    cur_job;
   logic               own;
   logic               is_slider;
   logic               gen_free;
   logic               acked;

   always_comb
   begin
      cur = board[sq];
      own = chess_pkg::is_own(cur, white_to_move);
      is_slider = cur[2:0] == chess_pkg::PIECE_BISHOP ||
                  cur[2:0] == chess_pkg::PIECE_ROOK ||
                  cur[2:0] == chess_pkg::PIECE_QUEEN;
      gen_free = is_slider ? (!slide_ack && !slide_busy) : (!leap_ack && !leap_busy);
      acked = (slide_req && slide_ack) || (leap_req && leap_ack);
      cur_job = '{sq: sq, piece: cur, white_to_move: white_to_move};
   end

   assign slide_job = cur_job;  // held while req is up
   assign leap_job = cur_job;
   assign scan_done = state == DONE;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         sq <= '0;
         slide_req <= 1'b0;
         leap_req <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE, DONE:
               if (start)
               begin
                  sq <= '0;
                  state <= SCAN;
               end
            SCAN:
               if (!own)
               begin
                  sq <= sq + 6'd1;
                  if (sq == 6'd63)
                     state <= DONE;
               end
               else if (gen_free)
               begin
                  slide_req <= is_slider;
                  leap_req <= !is_slider;
                  state <= REQ;
               end
            REQ:
               if (acked)
               begin
                  slide_req <= 1'b0;
                  leap_req <= 1'b0;
                  sq <= sq + 6'd1;
                  state <= (sq == 6'd63) ? DONE : SCAN;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

// File: hw/slider_gen.sv
`timescale 1ns/1ps

module slider_gen
(
   input  logic              clk,
   input  logic              reset,
   input  chess_pkg::board_t board,
   input  chess_pkg::job_t   job,
   input  logic              job_req,
   output logic              job_ack,
   output logic              busy,
   output logic              wr_req,
   output chess_pkg::move_t  wr_move,
   input  logic              wr_ack
);

   typedef enum logic [1:0] {IDLE, STEP, WRITE} state_t;

   state_t             state;
   chess_pkg::job_t    cur_job;
   chess_pkg::square_t pos;       // last square reached on the ray
   logic [2:0]         dir;
   logic [3:0]         dir_count;
   chess_pkg::offset_t step;
   chess_pkg::square_t target;
   chess_pkg::piece_t  target_piece;
   logic               on_board;
   logic               move_ok;
   logic               last_dir;
   logic               ray_stop;  // pending write is a capture
   logic               end_ray;

   always_comb
   begin
      step = chess_pkg::ray_dir(cur_job.piece[2:0], dir, dir_count);
      on_board = chess_pkg::step_sq(pos, step, target);
      target_piece = board[target];
      move_ok = on_board && !chess_pkg::is_own(target_piece, cur_job.white_to_move);
      last_dir = {1'b0, dir} == dir_count - 4'd1;
      end_ray = (state == STEP && !wr_ack && !move_ok) ||
                (state == WRITE && wr_ack && ray_stop);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         job_ack <= 1'b0;
         busy <= 1'b0;
         wr_req <= 1'b0;
      end
      else
      begin
         if (!job_req)
            job_ack <= 1'b0;
         case (state)
            IDLE:
               if (job_req && !job_ack)
               begin
                  cur_job <= job;
                  pos <= job.sq;
                  dir <= 3'd0;
                  job_ack <= 1'b1;
                  busy <= 1'b1;
                  state <= STEP;
               end
            STEP:
               if (!wr_ack && move_ok)  // wait for previous ack to drop
               begin
                  wr_move <= '{from_sq: cur_job.sq, to_sq: target,
                               piece: cur_job.piece, captured: target_piece};
                  wr_req <= 1'b1;
                  ray_stop <= target_piece[2:0] != chess_pkg::PIECE_EMPTY;
                  pos <= target;
                  state <= WRITE;
               end
            WRITE:
               if (wr_ack)
               begin
                  wr_req <= 1'b0;
                  state <= STEP;
               end
            default:
               state <= IDLE;
         endcase
         if (end_ray)
         begin
            pos <= cur_job.sq;  // next ray starts at home
            dir <= dir + 3'd1;
            if (last_dir)
            begin
               busy <= 1'b0;
               state <= IDLE;
            end
         end
      end
   end

endmodule

// File: hw/leaper_gen.sv
`timescale 1ns/1ps

module leaper_gen
(
   input  logic              clk,
   input  logic              reset,
   input  chess_pkg::board_t board,
   input  chess_pkg::job_t   job,
   input  logic              job_req,
   output logic              job_ack,
   output logic              busy,
   output logic              wr_req,
   output chess_pkg::move_t  wr_move,
   input  logic              wr_ack
);

   typedef enum logic [1:0] {IDLE, STEP, WRITE} state_t;

   state_t             state;
   chess_pkg::job_t    cur_job;
   logic [2:0]         idx;
   chess_pkg::offset_t off;
   chess_pkg::square_t target;
   chess_pkg::square_t ahead;     // square in front of a pawn
   chess_pkg::piece_t  target_piece;
   logic               on_board;
   logic               target_empty;
   logic               is_pawn;
   logic               home;
   logic signed [2:0]  fwd;
   logic               legal;
   logic               last_idx;
   logic               advance;

   always_comb
   begin
      is_pawn = cur_job.piece[2:0] == chess_pkg::PIECE_PAWN;
      fwd = cur_job.white_to_move ? 3'sd1 : -3'sd1;
      home = cur_job.sq[5:3] == (cur_job.white_to_move ? 3'd1 : 3'd6);
      ahead = cur_job.white_to_move ? cur_job.sq + 6'd8 : cur_job.sq - 6'd8;
      if (is_pawn)
         case (idx[1:0])
            2'd0: off = chess_pkg::make_offset(fwd, 0);
            2'd1: off = chess_pkg::make_offset(fwd * 2, 0);
            2'd2: off = chess_pkg::make_offset(fwd, -1);
            default: off = chess_pkg::make_offset(fwd, 1);
         endcase
      else
         off = chess_pkg::leap_offset(cur_job.piece[2:0], idx);
      on_board = chess_pkg::step_sq(cur_job.sq, off, target);
      target_piece = board[target];
      target_empty = target_piece[2:0] == chess_pkg::PIECE_EMPTY;
      if (!on_board)
         legal = 1'b0;
      else if (!is_pawn)
         legal = !chess_pkg::is_own(target_piece, cur_job.white_to_move);
      else
         case (idx[1:0])
            2'd0: legal = target_empty;
            2'd1: legal = home && target_empty &&
                          board[ahead][2:0] == chess_pkg::PIECE_EMPTY;
            default: legal = chess_pkg::is_opponent(target_piece, cur_job.white_to_move);
         endcase
      last_idx = idx == (is_pawn ? 3'd3 : 3'd7);
      advance = (state == STEP && !wr_ack && !legal) || (state == WRITE && wr_ack);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         job_ack <= 1'b0;
         busy <= 1'b0;
         wr_req <= 1'b0;
      end
      else
      begin
         if (!job_req)
            job_ack <= 1'b0;
         case (state)
            IDLE:
               if (job_req && !job_ack)
               begin
                  cur_job <= job;
                  idx <= 3'd0;
                  job_ack <= 1'b1;
                  busy <= 1'b1;
                  state <= STEP;
               end
            STEP:
               if (!wr_ack && legal)
               begin
                  wr_move <= '{from_sq: cur_job.sq, to_sq: target,
                               piece: cur_job.piece, captured: target_piece};
                  wr_req <= 1'b1;
                  state <= WRITE;
               end
            WRITE:
               if (wr_ack)
               begin
                  wr_req <= 1'b0;
                  state <= STEP;
               end
            default:
               state <= IDLE;
         endcase
         if (advance)
         begin
            idx <= idx + 3'd1;
            if (last_idx)
            begin
               busy <= 1'b0;
               state <= IDLE;
            end
         end
      end
   end

endmodule

// File: hw/move_arbiter.sv
`timescale 1ns/1ps

module move_arbiter #(
   parameter int NUM_GEN = 2
)
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic [NUM_GEN-1:0]             wr_req,
   input  chess_pkg::move_t [NUM_GEN-1:0] wr_move,
   output logic [NUM_GEN-1:0]             wr_ack,
   output logic                           store_we,
   output chess_pkg::move_t               store_data
);

   localparam int PW = (NUM_GEN > 1) ? $clog2(NUM_GEN) : 1;

   logic [PW-1:0]      last;  // most recent grant
   logic [PW-1:0]      grant;
   logic               grant_valid;
   logic [NUM_GEN-1:0] pending;

   always_comb
   begin
      int cand;
      pending = wr_req & ~wr_ack;  // acked requesters wait for req to drop
      grant = last;
      grant_valid = 1'b0;
      for (int k = 1; k <= NUM_GEN; k++)
      begin
         cand = (int'(last) + k) % NUM_GEN;
         if (!grant_valid && pending[cand])
         begin
            grant = PW'(cand);
            grant_valid = 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ack <= '0;
         store_we <= 1'b0;
         last <= '0;
      end
      else
      begin
         store_we <= grant_valid;
         for (int i = 0; i < NUM_GEN; i++)
            if (wr_ack[i] && !wr_req[i])
               wr_ack[i] <= 1'b0;
         if (grant_valid)
         begin
            wr_ack[grant] <= 1'b1;
            last <= grant;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant_valid)
         store_data <= wr_move[grant];
   end

endmodule

// File: hw/move_store.sv
`timescale 1ns/1ps

module move_store #(
   parameter int MOVE_DEPTH = 256
)
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          clear,
   input  logic                          we,
   input  chess_pkg::move_t              wdata,
   input  logic [$clog2(MOVE_DEPTH)-1:0] rd_index,
   output chess_pkg::move_t              rdata,
   output logic [$clog2(MOVE_DEPTH)-1:0] count
);

   localparam int AW = $clog2(MOVE_DEPTH);

   chess_pkg::move_t mem [MOVE_DEPTH];
   logic [AW-1:0]    wr_ptr;

   assign count = wr_ptr;  // next free slot is the count

   always_ff @(posedge clk)
   begin
      if (reset || clear)
         wr_ptr <= '0;
      else if (we)
         wr_ptr <= wr_ptr + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (we)
         mem[wr_ptr] <= wdata;
      rdata <= mem[rd_index];
   end

endmodule

// File: hw/move_gen_top.sv
`timescale 1ns/1ps

module move_gen_top #(
   parameter int MOVE_DEPTH = 256
)
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          board_valid,
   input  chess_pkg::board_t             board,
   input  logic                          white_to_move,
   input  logic                          clear_moves,
   input  logic [$clog2(MOVE_DEPTH)-1:0] move_index,
   output logic                          moves_ready,
   output logic [$clog2(MOVE_DEPTH)-1:0] move_count,
   output chess_pkg::move_t              move
);

   localparam int NUM_GEN = 2;  // 0 slider, 1 leaper

   typedef enum logic [1:0] {IDLE, SCAN, READY} state_t;

   state_t                         state;
   chess_pkg::board_t              board_q;
   logic                           white_to_move_q;
   logic                           start;
   logic                           scan_done;
   chess_pkg::job_t                slide_job;
   chess_pkg::job_t                leap_job;
   logic                           slide_req;
   logic                           leap_req;
   logic                           slide_ack;
   logic                           leap_ack;
   logic                           slide_busy;
   logic                           leap_busy;
   logic [NUM_GEN-1:0]             wr_req;
   logic [NUM_GEN-1:0]             wr_ack;
   chess_pkg::move_t [NUM_GEN-1:0] wr_move;
   logic                           store_we;
   chess_pkg::move_t               store_data;

   assign start = state == IDLE && board_valid;  // also clears the store
   assign moves_ready = state == READY;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= IDLE;
      else
         case (state)
            IDLE:
               if (board_valid)
                  state <= SCAN;
            SCAN:
               if (scan_done && !slide_busy && !leap_busy)
                  state <= READY;
            READY:
               if (clear_moves)
                  state <= IDLE;
            default:
               state <= IDLE;
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         board_q <= board;
         white_to_move_q <= white_to_move;
      end
   end

   square_scanner square_scanner_i (
      .clk(clk), .reset(reset), .start(start),
      .board(board_q), .white_to_move(white_to_move_q),
      .slide_job(slide_job), .leap_job(leap_job),
      .slide_req(slide_req), .leap_req(leap_req),
      .slide_ack(slide_ack), .leap_ack(leap_ack),
      .slide_busy(slide_busy), .leap_busy(leap_busy),
      .scan_done(scan_done)
   );

   slider_gen slider_gen_i (
      .clk(clk), .reset(reset), .board(board_q),
      .job(slide_job), .job_req(slide_req), .job_ack(slide_ack), .busy(slide_busy),
      .wr_req(wr_req[0]), .wr_move(wr_move[0]), .wr_ack(wr_ack[0])
   );

   leaper_gen leaper_gen_i (
      .clk(clk), .reset(reset), .board(board_q),
      .job(leap_job), .job_req(leap_req), .job_ack(leap_ack), .busy(leap_busy),
      .wr_req(wr_req[1]), .wr_move(wr_move[1]), .wr_ack(wr_ack[1])
   );

   move_arbiter #(.NUM_GEN(NUM_GEN)) move_arbiter_i (
      .clk(clk), .reset(reset),
      .wr_req(wr_req), .wr_move(wr_move), .wr_ack(wr_ack),
      .store_we(store_we), .store_data(store_data)
   );

   move_store #(.MOVE_DEPTH(MOVE_DEPTH)) move_store_i (
      .clk(clk), .reset(reset), .clear(start),
      .we(store_we), .wdata(store_data),
      .rd_index(move_index), .rdata(move), .count(move_count)
   );

endmodule

// File: testbench/tb_move_gen.sv
`timescale 1ns/1ps

module tb_move_gen;

   localparam int MOVE_DEPTH = 256;
   localparam int AW = $clog2(MOVE_DEPTH);
   localparam int MAX_CYCLES = 20000;  // 8 boards of well under 1000 cycles each
   localparam chess_pkg::piece_t NONE = 4'h0;

   logic              clk;
   logic              reset;
   logic              board_valid;
   chess_pkg::board_t board;
   logic              white_to_move;
   logic              clear_moves;
   logic [AW-1:0]     move_index;
   logic              moves_ready;
   logic [AW-1:0]     move_count;
   chess_pkg::move_t  move;

   chess_pkg::board_t setup;              // board under construction
   chess_pkg::move_t  expected_moves[$];
   int                cycles;

   move_gen_top #(.MOVE_DEPTH(MOVE_DEPTH)) move_gen_top_i (
      .clk(clk), .reset(reset), .board_valid(board_valid), .board(board),
      .white_to_move(white_to_move), .clear_moves(clear_moves),
      .move_index(move_index), .moves_ready(moves_ready),
      .move_count(move_count), .move(move)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         report_failure($sformatf("error %s: got 0x%h, expected 0x%h",
                                  name, actual, expected));
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES)
         report_failure($sformatf("timeout after %0d cycles, moves_ready never came",
                                  cycles));
   end

   // step to 2 ns after the next rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   function automatic chess_pkg::square_t square_of(input string name);
      logic [7:0] col;
      logic [7:0] row;
      col = name[0] - 8'h61;
      row = name[1] - 8'h31;
      return {row[2:0], col[2:0]};
   endfunction

   function automatic string square_name(input chess_pkg::square_t sq);
      return $sformatf("%c%0d", 8'h61 + sq[2:0], sq[5:3] + 1);
   endfunction

   function automatic string describe(input chess_pkg::move_t m);
      return $sformatf("%s to %s (piece 0x%h, captured 0x%h)", square_name(m.from_sq),
                       square_name(m.to_sq), m.piece, m.captured);
   endfunction

   function automatic chess_pkg::piece_t white(input logic [2:0] kind);
      return {1'b0, kind};
   endfunction

   function automatic chess_pkg::piece_t black(input logic [2:0] kind);
      return {1'b1, kind};
   endfunction

   task automatic place(input string name, input chess_pkg::piece_t p);
      setup[square_of(name)] = p;
   endtask

   task automatic add_move(input string from, input string to,
                           input chess_pkg::piece_t piece, input chess_pkg::piece_t captured);
      expected_moves.push_back('{from_sq: square_of(from), to_sq: square_of(to),
                                 piece: piece, captured: captured});
   endtask

   // len squares along one direction with any capture on the last
   task automatic add_ray(input string from, input chess_pkg::piece_t piece, input int dr,
                          input int dc, input int len, input chess_pkg::piece_t last_captured);
      chess_pkg::square_t f;
      int r;
      int c;
      f = square_of(from);
      for (int k = 1; k <= len; k++)
      begin
         r = int'(f[5:3]) + dr * k;
         c = int'(f[2:0]) + dc * k;
         expected_moves.push_back('{from_sq: f, to_sq: {r[2:0], c[2:0]}, piece: piece,
                                    captured: (k == len) ? last_captured : NONE});
      end
   endtask

   task automatic new_board();
      setup = '0;
      expected_moves.delete();
   endtask

   // load, wait for moves_ready, read back and compare as a set, then clear
   task automatic run_board(input logic side_white);
      chess_pkg::move_t m;
      int               hit;
      logic             seen [MOVE_DEPTH];
      board = setup;
      white_to_move = side_white;
      board_valid = 1'b1;
      do
         next_cycle();
      while (!moves_ready);
      board_valid = 1'b0;
      foreach (seen[j])
         seen[j] = 1'b0;
      for (int i = 0; i < int'(move_count); i++)
      begin
         move_index = AW'(i);
         next_cycle();
         m = move;
         hit = -1;
         foreach (expected_moves[j])
            if (expected_moves[j] == m)
               hit = j;
         if (hit < 0)
            report_failure($sformatf("unexpected move %s at index %0d", describe(m), i));
         if (seen[hit])
            report_failure($sformatf("move %s stored twice", describe(m)));
         seen[hit] = 1'b1;
      end
      foreach (expected_moves[j])
         if (!seen[j])
            report_failure($sformatf("move %s is missing", describe(expected_moves[j])));
      check_value("move_count", 32'(move_count), 32'(expected_moves.size()));
      clear_moves = 1'b1;
      next_cycle();
      clear_moves = 1'b0;
      check_value("moves_ready", 32'(moves_ready), 32'd0);
   endtask

   task automatic knight_in_corner();
      check_value("moves_ready", 32'(moves_ready), 32'd0);  // just out of reset
      new_board();
      place("a1", white(chess_pkg::PIECE_KNIGHT));
      add_move("a1", "b3", white(chess_pkg::PIECE_KNIGHT), NONE);
      add_move("a1", "c2", white(chess_pkg::PIECE_KNIGHT), NONE);
      run_board(1'b1);
   endtask

   task automatic rook_with_blockers();
      chess_pkg::piece_t rook;
      rook = white(chess_pkg::PIECE_ROOK);
      new_board();
      place("d4", rook);
      place("d6", white(chess_pkg::PIECE_PAWN));
      place("g4", black(chess_pkg::PIECE_PAWN));
      add_ray("d4", rook, 1, 0, 1, NONE);   // stops before d6
      add_ray("d4", rook, -1, 0, 3, NONE);
      add_ray("d4", rook, 0, 1, 3, black(chess_pkg::PIECE_PAWN));
      add_ray("d4", rook, 0, -1, 3, NONE);
      add_move("d6", "d7", white(chess_pkg::PIECE_PAWN), NONE);
      run_board(1'b1);
   endtask

   // slider and leaper busy at once so writes go through arbitration
   task automatic queen_and_king_together();
      chess_pkg::piece_t queen;
      chess_pkg::piece_t king;
      queen = white(chess_pkg::PIECE_QUEEN);
      king = white(chess_pkg::PIECE_KING);
      new_board();
      place("a1", queen);
      place("d3", king);
      add_ray("a1", queen, 1, 0, 7, NONE);
      add_ray("a1", queen, 0, 1, 7, NONE);
      add_ray("a1", queen, 1, 1, 7, NONE);
      add_move("d3", "c2", king, NONE);
      add_move("d3", "d2", king, NONE);
      add_move("d3", "e2", king, NONE);
      add_move("d3", "c3", king, NONE);
      add_move("d3", "e3", king, NONE);
      add_move("d3", "c4", king, NONE);
      add_move("d3", "d4", king, NONE);
      add_move("d3", "e4", king, NONE);
      run_board(1'b1);
   endtask

   task automatic pawn_advances_and_captures();
      chess_pkg::piece_t pawn;
      pawn = white(chess_pkg::PIECE_PAWN);
      new_board();
      place("e2", pawn);
      add_move("e2", "e3", pawn, NONE);
      add_move("e2", "e4", pawn, NONE);
      run_board(1'b1);
      place("d3", black(chess_pkg::PIECE_KNIGHT));  // now a capture target
      add_move("e2", "d3", pawn, black(chess_pkg::PIECE_KNIGHT));
      run_board(1'b1);
      new_board();
      place("e2", pawn);
      place("d3", black(chess_pkg::PIECE_KNIGHT));
      place("e3", black(chess_pkg::PIECE_PAWN));    // blocks single and double
      add_move("e2", "d3", pawn, black(chess_pkg::PIECE_KNIGHT));
      run_board(1'b1);
   endtask

   task automatic black_side_moves();
      new_board();
      place("e7", black(chess_pkg::PIECE_PAWN));
      place("g8", black(chess_pkg::PIECE_KNIGHT));
      place("d6", white(chess_pkg::PIECE_KNIGHT));
      place("d2", white(chess_pkg::PIECE_PAWN));
      add_ray("e7", black(chess_pkg::PIECE_PAWN), -1, 0, 2, NONE);
      add_move("e7", "d6", black(chess_pkg::PIECE_PAWN), white(chess_pkg::PIECE_KNIGHT));
      add_move("g8", "f6", black(chess_pkg::PIECE_KNIGHT), NONE);
      add_move("g8", "h6", black(chess_pkg::PIECE_KNIGHT), NONE);
      run_board(1'b0);
   endtask

   // previous board left 29 moves in the store
   task automatic clear_then_new_board();
      new_board();
      place("a7", white(chess_pkg::PIECE_PAWN));
      add_move("a7", "a8", white(chess_pkg::PIECE_PAWN), NONE);
      run_board(1'b1);
   endtask

   initial
   begin
      reset = 1'b1;
      board_valid = 1'b0;
      board = '0;
      white_to_move = 1'b1;
      clear_moves = 1'b0;
      move_index = '0;
      cycles = 0;
      repeat (10)
         @(posedge clk);
      #2;
      reset = 1'b0;
      next_cycle();
      knight_in_corner();
      rook_with_blockers();
      queen_and_king_together();
      clear_then_new_board();
      pawn_advances_and_captures();
      black_side_moves();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: filelist.f
hw/chess_pkg.sv
hw/square_scanner.sv
hw/slider_gen.sv
hw/leaper_gen.sv
hw/move_arbiter.sv
hw/move_store.sv
hw/move_gen_top.sv
testbench/tb_move_gen.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_move_gen
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
